/* sim.f */
hw/stbuf_pkg.sv
hw/shift_reg_fifo.sv
hw/ram_fifo.sv
hw/apb_status_regs.sv
hw/stbuf_top.sv
test/tb_stbuf.sv

/* Bender.yml */
package:
  name: stbuf

# package first, then the RTL in dependency order
sources:
  - hw/stbuf_pkg.sv
  - hw/shift_reg_fifo.sv
  - hw/ram_fifo.sv
  - hw/apb_status_regs.sv
  - hw/stbuf_top.sv

  # testbench, top module tb_stbuf
  - target: test
    files:
      - test/tb_stbuf.sv

/* test/tb_stbuf.sv */
`timescale 1ns/1ps

module tb_stbuf;

  localparam int DATA_W    = 32;
  localparam int SRL_DEPTH = 16;
  localparam int RAM_DEPTH = 8;   // default P_RAM_AW of 3
  localparam int RAM_LSB   = 8;   // ram level field in REG_LEVEL

  logic                clk = 1'b0;
  logic                arst_n;
  logic                push;
  logic [DATA_W-1:0]   push_data;
  logic                pop;
  logic                in_full;
  logic                out_valid;
  logic [DATA_W-1:0]   out_data;
  stbuf_pkg::apb_req_t apb_req;
  stbuf_pkg::apb_rsp_t apb_rsp;

  logic [DATA_W-1:0] model_q [$];  // accepted words, oldest first
  logic              exp_overrun;
  logic              exp_underrun;
  int                data_errors;
  int                reg_errors;
  int                timeout_errors;

  always #2 clk = ~clk;

  stbuf_top u_dut (
    .i_clk       (clk),
    .i_arst_n    (arst_n),
    .i_push      (push),
    .i_push_data (push_data),
    .o_in_full   (in_full),
    .o_out_valid (out_valid),
    .o_out_data  (out_data),
    .i_pop       (pop),
    .i_apb       (apb_req),
    .o_apb       (apb_rsp)
  );

  function automatic logic [31:0] expected_err();
    return {30'b0, exp_underrun, exp_overrun};
  endfunction

  // setup phase, then access phase, response sampled mid-cycle
  task automatic apb_access(input stbuf_pkg::apb_addr_t addr, input logic write,
                            input stbuf_pkg::apb_data_t wdata,
                            output stbuf_pkg::apb_data_t rdata, output logic slverr);
    int   waited;
    logic done;
    waited = 0;
    done   = 1'b0;
    rdata  = '0;
    slverr = 1'b0;
    @(negedge clk);
    push            = 1'b0;
    pop             = 1'b0;
    apb_req.paddr   = addr;
    apb_req.pwrite  = write;
    apb_req.pwdata  = wdata;
    apb_req.psel    = 1'b1;
    apb_req.penable = 1'b0;
    @(negedge clk);
    apb_req.penable = 1'b1;
    while (!done && waited < 8) begin
      #1;
      if (apb_rsp.pready) begin
        rdata  = apb_rsp.prdata;
        slverr = apb_rsp.pslverr;
        done   = 1'b1;
      end else begin
        waited++;
        @(negedge clk);
      end
    end
    if (!done) begin
      $display("APB access to 0x%h never saw pready", addr);
      timeout_errors++;
    end
    @(negedge clk);
    apb_req.psel    = 1'b0;
    apb_req.penable = 1'b0;
  endtask

  task automatic apb_write(input stbuf_pkg::apb_addr_t addr, input stbuf_pkg::apb_data_t data,
                           output logic slverr);
    stbuf_pkg::apb_data_t unused;
    apb_access(addr, 1'b1, data, unused, slverr);
  endtask

  task automatic apb_read(input stbuf_pkg::apb_addr_t addr, output stbuf_pkg::apb_data_t data,
                          output logic slverr);
    apb_access(addr, 1'b0, '0, data, slverr);
  endtask

  task automatic expect_reg(input stbuf_pkg::apb_addr_t addr, input logic [31:0] exp,
                            input string name);
    stbuf_pkg::apb_data_t got;
    logic                 err;
    apb_read(addr, got, err);
    if (got !== exp) begin
      $display("FAILED %s: got 0x%h expected 0x%h", name, got, exp);
      reg_errors++;
    end
    if (err !== 1'b0) begin
      $display("FAILED pslverr on %s: got 0x%h expected 0x0", name, err);
      reg_errors++;
    end
  endtask

  // one stream cycle; guarded holds back pushes on full and pops on empty
  task automatic stream_cycle(input logic want_push, input logic want_pop, input logic guarded);
    logic [DATA_W-1:0] word;
    logic [DATA_W-1:0] head;
    @(negedge clk);
    word      = $urandom;
    push      = want_push && !(guarded && in_full);
    pop       = want_pop && !(guarded && !out_valid);
    push_data = word;
    if (out_valid && model_q.size() == 0) begin
      $display("o_out_valid is high but no word is expected");
      data_errors++;
    end
    if (push) begin
      if (in_full) begin
        exp_overrun = 1'b1;  // word is dropped
      end else begin
        model_q.push_back(word);
      end
    end
    if (pop) begin
      if (!out_valid) begin
        exp_underrun = 1'b1;
      end else if (model_q.size() > 0) begin
        head = model_q.pop_front();
        if (out_data !== head) begin
          $display("FAILED o_out_data: got 0x%h expected 0x%h", out_data, head);
          data_errors++;
        end
      end
    end
  endtask

  task automatic drain_stream(input int max_cycles);
    int cycles;
    cycles = 0;
    while (model_q.size() > 0 && cycles < max_cycles) begin
      stream_cycle(1'b0, 1'b1, 1'b1);
      cycles++;
    end
    stream_cycle(1'b0, 1'b0, 1'b1);
    if (model_q.size() > 0) begin
      $display("stream did not drain, %0d words never came out", model_q.size());
      timeout_errors++;
    end
  endtask

  task automatic wait_level(input logic [31:0] exp, input int max_reads);
    stbuf_pkg::apb_data_t got;
    logic                 err;
    int                   reads;
    reads = 0;
    got   = ~exp;
    while (got !== exp && reads < max_reads) begin
      apb_read(stbuf_pkg::REG_LEVEL, got, err);
      reads++;
    end
    if (got !== exp) begin
      $display("FAILED REG_LEVEL: got 0x%h expected 0x%h", got, exp);
      timeout_errors++;
    end
  endtask

  initial begin
    stbuf_pkg::apb_data_t rdata;
    logic                 slverr;
    int                   seed_val;
    seed_val       = $urandom(6);
    arst_n         = 1'b0;
    push           = 1'b0;
    push_data      = '0;
    pop            = 1'b0;
    apb_req        = '0;
    exp_overrun    = 1'b0;
    exp_underrun   = 1'b0;
    data_errors    = 0;
    reg_errors     = 0;
    timeout_errors = 0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;

    // reset values
    if (apb_rsp !== '0) begin
      $display("FAILED o_apb: got 0x%h expected 0x0", apb_rsp);
      reg_errors++;
    end
    if (out_valid !== 1'b0 || in_full !== 1'b0) begin
      $display("FAILED o_out_valid/o_in_full: got 0x%h expected 0x0", {out_valid, in_full});
      data_errors++;
    end
    expect_reg(stbuf_pkg::REG_CTRL, 32'h0, "REG_CTRL");
    expect_reg(stbuf_pkg::REG_ERR, 32'h0, "REG_ERR");
    expect_reg(stbuf_pkg::REG_STATUS, 32'h5, "REG_STATUS");
    expect_reg(stbuf_pkg::REG_LEVEL, 32'h0, "REG_LEVEL");

    // fill the shift FIFO with transfers off, one push too many
    repeat (SRL_DEPTH + 1) stream_cycle(1'b1, 1'b0, 1'b0);
    stream_cycle(1'b0, 1'b0, 1'b1);
    if (model_q.size() != SRL_DEPTH || !exp_overrun) begin
      $display("overfill accepted %0d words instead of %0d", model_q.size(), SRL_DEPTH);
      data_errors++;
    end
    if (in_full !== 1'b1) begin
      $display("FAILED o_in_full: got 0x%h expected 0x1", in_full);
      data_errors++;
    end
    expect_reg(stbuf_pkg::REG_LEVEL, SRL_DEPTH, "REG_LEVEL");
    expect_reg(stbuf_pkg::REG_STATUS, 32'h6, "REG_STATUS");
    expect_reg(stbuf_pkg::REG_ERR, 32'h1, "REG_ERR");
    apb_write(stbuf_pkg::REG_ERR, 32'h1, slverr);
    exp_overrun = 1'b0;
    expect_reg(stbuf_pkg::REG_ERR, expected_err(), "REG_ERR");

    // random traffic with transfers on
    apb_write(stbuf_pkg::REG_CTRL, 32'h1, slverr);
    for (int i = 0; i < 600; i++) begin
      stream_cycle($urandom % 2, ($urandom % 3) != 0, 1'b1);
    end
    drain_stream(200);
    expect_reg(stbuf_pkg::REG_ERR, expected_err(), "REG_ERR");
    expect_reg(stbuf_pkg::REG_LEVEL, 32'h0, "REG_LEVEL");
    expect_reg(stbuf_pkg::REG_STATUS, 32'h5, "REG_STATUS");

    // pop on an empty output, then the stream must carry on in order
    stream_cycle(1'b0, 1'b1, 1'b0);
    stream_cycle(1'b0, 1'b0, 1'b1);
    expect_reg(stbuf_pkg::REG_ERR, expected_err(), "REG_ERR");
    repeat (5) stream_cycle(1'b1, 1'b0, 1'b1);
    drain_stream(100);
    apb_write(stbuf_pkg::REG_ERR, 32'h2, slverr);
    exp_underrun = 1'b0;
    expect_reg(stbuf_pkg::REG_ERR, expected_err(), "REG_ERR");

    // partial fill, ram side ends up full
    repeat (SRL_DEPTH - 4) stream_cycle(1'b1, 1'b0, 1'b1);
    stream_cycle(1'b0, 1'b0, 1'b1);
    wait_level((RAM_DEPTH << RAM_LSB) | (SRL_DEPTH - 4 - RAM_DEPTH), 20);
    expect_reg(stbuf_pkg::REG_STATUS, 32'h8, "REG_STATUS");
    apb_write(stbuf_pkg::REG_CTRL, 32'h3, slverr);
    model_q.delete();
    expect_reg(stbuf_pkg::REG_LEVEL, 32'h0, "REG_LEVEL");
    expect_reg(stbuf_pkg::REG_STATUS, 32'h5, "REG_STATUS");
    expect_reg(stbuf_pkg::REG_CTRL, 32'h1, "REG_CTRL");  // flush bit self-clears
    if (out_valid !== 1'b0) begin
      $display("FAILED o_out_valid: got 0x%h expected 0x0", out_valid);
      data_errors++;
    end

    // unmapped offset
    apb_read(8'h10, rdata, slverr);
    if (slverr !== 1'b1) begin
      $display("FAILED pslverr: got 0x%h expected 0x1", slverr);
      reg_errors++;
    end
    apb_write(8'h10, 32'hffff_ffff, slverr);
    if (slverr !== 1'b1) begin
      $display("FAILED pslverr: got 0x%h expected 0x1", slverr);
      reg_errors++;
    end
    expect_reg(stbuf_pkg::REG_CTRL, 32'h1, "REG_CTRL");

    $display("errors: data %0d, register %0d, timeout %0d",
             data_errors, reg_errors, timeout_errors);
    if (data_errors + reg_errors + timeout_errors == 0) begin
      $display("Test OK");
    end else begin
      $display("Test FAILED");
    end
    $finish;
  end

endmodule

/* hw/stbuf_top.sv */
`timescale 1ns/1ps

module stbuf_top #(
  parameter int P_DATA_W = 32,
  parameter int P_RAM_AW = 3
) (
  input  logic                i_clk,
  input  logic                i_arst_n,
  input  logic                i_push,
  input  logic [P_DATA_W-1:0] i_push_data,
  output logic                o_in_full,
  output logic                o_out_valid,
  output logic [P_DATA_W-1:0] o_out_data,
  input  logic                i_pop,
  input  stbuf_pkg::apb_req_t i_apb,
  output stbuf_pkg::apb_rsp_t o_apb
);

  stbuf_pkg::fifo_flags_t srl_flags;
  stbuf_pkg::fifo_flags_t ram_flags;
  stbuf_pkg::srl_level_t  srl_level;
  logic [P_RAM_AW:0]      ram_level;
  logic [P_DATA_W-1:0]    srl_head;
  logic                   xfer;       // pops the shift FIFO and pushes the RAM FIFO
  logic                   enable;
  logic                   flush;
  logic                   drop;
  logic                   underrun;

  // one word per cycle while enabled and not blocked
  assign xfer = enable & ~srl_flags.empty & ~ram_flags.full;

  shift_reg_fifo #(
    .P_DATA_W (P_DATA_W)
  ) u_srl_fifo (
    .i_clk       (i_clk),
    .i_arst_n    (i_arst_n),
    .i_flush     (flush),
    .i_push      (i_push),
    .i_push_data (i_push_data),
    .i_pop       (xfer),
    .o_head      (srl_head),
    .o_flags     (srl_flags),
    .o_level     (srl_level),
    .o_drop      (drop)
  );

  ram_fifo #(
    .P_DATA_W (P_DATA_W),
    .P_RAM_AW (P_RAM_AW)
  ) u_ram_fifo (
    .i_clk       (i_clk),
    .i_arst_n    (i_arst_n),
    .i_flush     (flush),
    .i_push      (xfer),
    .i_push_data (srl_head),
    .i_pop       (i_pop),
    .o_head      (o_out_data),
    .o_flags     (ram_flags),
    .o_level     (ram_level),
    .o_underrun  (underrun)
  );

  apb_status_regs #(
    .P_RAM_AW (P_RAM_AW)
  ) u_regs (
    .i_clk          (i_clk),
    .i_arst_n       (i_arst_n),
    .i_apb          (i_apb),
    .o_apb          (o_apb),
    .i_srl_flags    (srl_flags),
    .i_ram_flags    (ram_flags),
    .i_srl_level    (srl_level),
    .i_ram_level    (ram_level),
    .i_overrun_evt  (drop),
    .i_underrun_evt (underrun),
    .o_enable       (enable),
    .o_flush        (flush)
  );

  assign o_in_full   = srl_flags.full;
  assign o_out_valid = ~ram_flags.empty;  // fall-through head is valid

endmodule

/* hw/apb_status_regs.sv */
`timescale 1ns/1ps

module apb_status_regs #(
  parameter int P_RAM_AW = 3
) (
  input  logic                   i_clk,
  input  logic                   i_arst_n,
  input  stbuf_pkg::apb_req_t    i_apb,
  output stbuf_pkg::apb_rsp_t    o_apb,
  input  stbuf_pkg::fifo_flags_t i_srl_flags,
  input  stbuf_pkg::fifo_flags_t i_ram_flags,
  input  stbuf_pkg::srl_level_t  i_srl_level,
  input  logic [P_RAM_AW:0]      i_ram_level,
  input  logic                   i_overrun_evt,
  input  logic                   i_underrun_evt,
  output logic                   o_enable,
  output logic                   o_flush
);

  logic                 access;
  logic                 wr;
  logic                 hit_ctrl;
  logic                 hit_status;
  logic                 hit_level;
  logic                 hit_err;
  logic                 addr_ok;
  logic                 overrun;
  logic                 underrun;
  stbuf_pkg::apb_data_t rdata;

  // access phase, slave never stalls
  assign access = i_apb.psel & i_apb.penable;
  assign wr     = access & i_apb.pwrite;

  assign hit_ctrl   = (i_apb.paddr == stbuf_pkg::REG_CTRL);
  assign hit_status = (i_apb.paddr == stbuf_pkg::REG_STATUS);
  assign hit_level  = (i_apb.paddr == stbuf_pkg::REG_LEVEL);
  assign hit_err    = (i_apb.paddr == stbuf_pkg::REG_ERR);
  assign addr_ok    = hit_ctrl | hit_status | hit_level | hit_err;

  // control register, flush lives for one cycle only
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_enable <= 1'b0;
      o_flush  <= 1'b0;
    end else begin
      o_flush <= wr & hit_ctrl & i_apb.pwdata[stbuf_pkg::CTRL_FLUSH_BIT];
      if (wr && hit_ctrl) begin
        o_enable <= i_apb.pwdata[stbuf_pkg::CTRL_ENABLE_BIT];
      end
    end
  end

  // sticky error bits, a new event beats the clear
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      overrun  <= 1'b0;
      underrun <= 1'b0;
    end else begin
      if (i_overrun_evt) begin
        overrun <= 1'b1;
      end else if (wr && hit_err && i_apb.pwdata[stbuf_pkg::ERR_OVERRUN_BIT]) begin
        overrun <= 1'b0;
      end
      if (i_underrun_evt) begin
        underrun <= 1'b1;
      end else if (wr && hit_err && i_apb.pwdata[stbuf_pkg::ERR_UNDERRUN_BIT]) begin
        underrun <= 1'b0;
      end
    end
  end

  // read mux
  always_comb begin
    rdata = '0;
    if (hit_ctrl) begin
      rdata[stbuf_pkg::CTRL_ENABLE_BIT] = o_enable;  // flush reads back as 0
    end else if (hit_status) begin
      rdata[0] = i_srl_flags.empty;
      rdata[1] = i_srl_flags.full;
      rdata[2] = i_ram_flags.empty;
      rdata[3] = i_ram_flags.full;
    end else if (hit_level) begin
      rdata[stbuf_pkg::SRL_LEVEL_W-1:0]                  = i_srl_level;
      rdata[stbuf_pkg::LEVEL_RAM_LSB +: P_RAM_AW + 1]    = i_ram_level;
    end else if (hit_err) begin
      rdata[stbuf_pkg::ERR_OVERRUN_BIT]  = overrun;
      rdata[stbuf_pkg::ERR_UNDERRUN_BIT] = underrun;
    end
  end

  // response only during the access phase
  assign o_apb.prdata  = (access && !i_apb.pwrite) ? rdata : '0;
  assign o_apb.pready  = access;
  assign o_apb.pslverr = access & ~addr_ok;

  // protocol checks on the master side
  a_penable_psel: assert property (
    @(posedge i_clk) disable iff (!i_arst_n)
    i_apb.penable |-> i_apb.psel
  );

  // setup phase is always followed by its access phase
  a_setup_access: assert property (
    @(posedge i_clk) disable iff (!i_arst_n)
    (i_apb.psel && !i_apb.penable) |=> (i_apb.psel && i_apb.penable)
  );

endmodule

/* hw/ram_fifo.sv */
`timescale 1ns/1ps

module ram_fifo #(
  parameter int P_DATA_W = 32,
  parameter int P_RAM_AW = 3
) (
  input  logic                   i_clk,
  input  logic                   i_arst_n,
  input  logic                   i_flush,
  input  logic                   i_push,
  input  logic [P_DATA_W-1:0]    i_push_data,
  input  logic                   i_pop,
  output logic [P_DATA_W-1:0]    o_head,
  output stbuf_pkg::fifo_flags_t o_flags,
  output logic [P_RAM_AW:0]      o_level,
  output logic                   o_underrun
);

  localparam int DEPTH = 1 << P_RAM_AW;

  logic [P_DATA_W-1:0] mem [DEPTH];
  logic [P_RAM_AW-1:0] wr_ptr;
  logic [P_RAM_AW-1:0] rd_ptr;
  logic [P_RAM_AW:0]   count;
  logic                full;
  logic                empty;
  logic                pop_ok;

  assign full   = (count == (P_RAM_AW + 1)'(DEPTH));
  assign empty  = (count == '0);
  assign pop_ok = i_pop & ~empty;

  // storage, written at the push edge
  always_ff @(posedge i_clk) begin
    if (i_push) begin
      mem[wr_ptr] <= i_push_data;
    end
  end

  // fall-through head, a new word shows one cycle after its push
  assign o_head = mem[rd_ptr];

  // pointers wrap on their own width
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else if (i_flush) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (i_push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop_ok) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
    end
  end

  // separate count keeps full and empty apart when the pointers meet
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      count <= '0;
    end else if (i_flush) begin
      count <= '0;
    end else begin
      case ({i_push, pop_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_underrun <= 1'b0;
    end else begin
      o_underrun <= i_pop & empty;  // pop ignored, reported next cycle
    end
  end

  assign o_flags.empty = empty;
  assign o_flags.full  = full;
  assign o_level       = count;

  // the transfer path upstream must hold off while full
  a_no_push_full: assert property (
    @(posedge i_clk) disable iff (!i_arst_n)
    !(i_push && full)
  );

endmodule

/* hw/shift_reg_fifo.sv */
`timescale 1ns/1ps

module shift_reg_fifo #(
  parameter int P_DATA_W = 32
) (
  input  logic                   i_clk,
  input  logic                   i_arst_n,
  input  logic                   i_flush,
  input  logic                   i_push,
  input  logic [P_DATA_W-1:0]    i_push_data,
  input  logic                   i_pop,
  output logic [P_DATA_W-1:0]    o_head,
  output stbuf_pkg::fifo_flags_t o_flags,
  output stbuf_pkg::srl_level_t  o_level,
  output logic                   o_drop
);

  localparam int IDX_W = $clog2(stbuf_pkg::SRL_DEPTH);

  logic [P_DATA_W-1:0]   mem [stbuf_pkg::SRL_DEPTH];
  stbuf_pkg::srl_level_t level;
  stbuf_pkg::srl_level_t level_m1;
  logic [IDX_W-1:0]      rd_idx;
  logic                  full;
  logic                  empty;
  logic                  push_ok;
  logic                  pop_ok;

  assign full    = (level == stbuf_pkg::srl_level_t'(stbuf_pkg::SRL_DEPTH));
  assign empty   = (level == '0);
  assign push_ok = i_push & ~full;  // dropped when full, even with a pop
  assign pop_ok  = i_pop & ~empty;

  // oldest word sits at level-1, newest always at index 0
  assign level_m1 = level - 1'b1;
  assign rd_idx   = level_m1[IDX_W-1:0];
  assign o_head   = mem[rd_idx];

  // tapped shift register, shifts on every accepted push
  always_ff @(posedge i_clk) begin
    if (push_ok) begin
      mem[0] <= i_push_data;
      for (int i = 1; i < stbuf_pkg::SRL_DEPTH; i++) begin
        mem[i] <= mem[i-1];
      end
    end
  end

  // occupancy doubles as the read address
  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      level <= '0;
    end else if (i_flush) begin
      level <= '0;
    end else begin
      case ({push_ok, pop_ok})
        2'b10:   level <= level + 1'b1;
        2'b01:   level <= level - 1'b1;
        default: level <= level;  // idle, or push and pop together
      endcase
    end
  end

  always_ff @(posedge i_clk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      o_drop <= 1'b0;
    end else begin
      o_drop <= i_push & full;  // one-cycle pulse per lost word
    end
  end

  assign o_flags.empty = empty;
  assign o_flags.full  = full;
  assign o_level       = level;

  // the read address must stay inside the tap range
  a_level_range: assert property (
    @(posedge i_clk) disable iff (!i_arst_n)
    level <= stbuf_pkg::srl_level_t'(stbuf_pkg::SRL_DEPTH)
  );

endmodule

/* hw/stbuf_pkg.sv */
package stbuf_pkg;

  // shift FIFO geometry
  localparam int SRL_DEPTH   = 16;
  localparam int SRL_LEVEL_W = $clog2(SRL_DEPTH + 1);  // 0..16 needs 5 bits

  typedef logic [SRL_LEVEL_W-1:0] srl_level_t;

  // apb widths
  typedef logic [7:0]  apb_addr_t;
  typedef logic [31:0] apb_data_t;

  // master to slave
  typedef struct packed {
    apb_addr_t paddr;
    logic      psel;
    logic      penable;
    logic      pwrite;
    apb_data_t pwdata;
  } apb_req_t;

  // slave to master
  typedef struct packed {
    apb_data_t prdata;
    logic      pready;
    logic      pslverr;
  } apb_rsp_t;

  // status bits common to both FIFOs
  typedef struct packed {
    logic empty;
    logic full;
  } fifo_flags_t;

  // register map
  localparam apb_addr_t REG_CTRL   = 8'h00;
  localparam apb_addr_t REG_STATUS = 8'h04;
  localparam apb_addr_t REG_LEVEL  = 8'h08;
  localparam apb_addr_t REG_ERR    = 8'h0C;

  // field positions
  localparam int CTRL_ENABLE_BIT  = 0;
  localparam int CTRL_FLUSH_BIT   = 1;  // self-clearing
  localparam int ERR_OVERRUN_BIT  = 0;
  localparam int ERR_UNDERRUN_BIT = 1;
  localparam int LEVEL_RAM_LSB    = 8;  // ram level sits above the srl level

endpackage
